//--- bootPkg.sv
`default_nettype none

package bootPkg;

    // instruction memory geometry
    localparam int memDepth = 256;
    localparam int memAddrWidth = 8;
    localparam int wordWidth = 32;

    // addi x0, x0, 0
    localparam logic [wordWidth-1:0] nopWord = 32'h0000_0013;

    // 115200 baud from a 27 MHz clock
    localparam int defaultClksPerBit = 234;

    // serial receiver states
    typedef enum logic [2:0] {
        rxIdle,
        rxStart,
        rxData,
        rxStop
    } rxState_t;

    // program loader states
    typedef enum logic [1:0] {
        loadGetSize,
        loadGetWord,
        loadDone
    } loadState_t;

endpackage

`default_nettype wire

//--- uartRx.sv
`default_nettype none
`timescale 1ns/1ps

module uartRx #(
    parameter int clksPerBit = bootPkg::defaultClksPerBit
) (
    input  wire        clk,
    input  wire        rstN,
    input  wire        rx,
    output logic [7:0] rxByte,
    output logic       rxValid,
    output logic       frameError
);
    import bootPkg::*;

    localparam int cntWidth = (clksPerBit > 2) ? $clog2(clksPerBit) : 1;
    localparam logic [cntWidth-1:0] bitLast = cntWidth'(clksPerBit - 1);
    localparam logic [cntWidth-1:0] halfLast = cntWidth'(clksPerBit / 2 - 1);

    logic rxMeta;
    logic rxSync;
    rxState_t state;
    logic [cntWidth-1:0] cnt;
    logic [3:0] bitIdx;
    logic [7:0] shiftReg;
    logic bitTick;

    // two-flop synchronizer on a line that idles high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    // end of a full bit period in data or stop
    assign bitTick = (cnt == bitLast);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= rxIdle;
            cnt <= '0;
            bitIdx <= '0;
            rxValid <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            frameError <= 1'b0;
            unique case (state)
                rxIdle: begin
                    if (!rxSync) begin
                        state <= rxStart;
                        cnt <= '0;
                        bitIdx <= '0;
                    end
                end
                rxStart: begin
                    if (cnt == halfLast) begin
                        cnt <= '0;
                        // start bit gone high again means a glitch
                        if (rxSync) begin
                            state <= rxIdle;
                        end else begin
                            state <= rxData;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rxData: begin
                    if (bitTick) begin
                        cnt <= '0;
                        if (bitIdx == 4'd7) begin
                            state <= rxStop;
                        end else begin
                            bitIdx <= bitIdx + 4'd1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rxStop: begin
                    if (bitTick) begin
                        cnt <= '0;
                        state <= rxIdle;
                        rxValid <= rxSync;
                        frameError <= !rxSync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= rxIdle;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == rxData && bitTick) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if (state == rxStop && bitTick) begin
            rxByte <= shiftReg;
        end
    end

    // a frame ends either good or bad but never both
    aValidXorError: assert property (
        @(posedge clk) disable iff (!rstN) !(rxValid && frameError)
    );

    aBitIdxRange: assert property (
        @(posedge clk) disable iff (!rstN) (state != rxData) |-> (bitIdx <= 4'd7)
    );

endmodule

`default_nettype wire

//--- progLoader.sv
`default_nettype none
`timescale 1ns/1ps

module progLoader (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire  [7:0]                          rxByte,
    input  wire                                 rxValid,
    output logic                                wrEn,
    output logic [bootPkg::memAddrWidth-1:0]    wrAddr,
    output logic [bootPkg::wordWidth-1:0]       wrData,
    output logic                                cpuEnable
);
    import bootPkg::*;

    loadState_t state;
    logic [7:0] progSize;
    logic [1:0] byteCnt;
    logic [memAddrWidth-1:0] wordIdx;
    logic [wordWidth-1:0] wordReg;
    logic wordComplete;
    logic lastWord;

    // fourth byte of the current word has arrived
    assign wordComplete = rxValid && (state == loadGetWord) && (byteCnt == 2'd3);

    // 8-bit wrap makes a length of 0 stand for 256 words
    assign lastWord = (wordIdx == progSize - 8'd1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= loadGetSize;
            progSize <= '0;
            byteCnt <= '0;
            wordIdx <= '0;
            wrEn <= 1'b0;
            cpuEnable <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            if (rxValid) begin
                unique case (state)
                    loadGetSize: begin
                        progSize <= rxByte;
                        byteCnt <= '0;
                        wordIdx <= '0;
                        state <= loadGetWord;
                    end
                    loadGetWord: begin
                        byteCnt <= byteCnt + 2'd1;
                        if (wordComplete) begin
                            wrEn <= 1'b1;
                            wordIdx <= wordIdx + 1'b1;
                            if (lastWord) begin
                                state <= loadDone;
                                cpuEnable <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        // trailing bytes ignored once loaded
                        state <= loadDone;
                    end
                endcase
            end
        end
    end

    // msb arrives first so each new byte enters at the low end
    always_ff @(posedge clk) begin
        if (rxValid && state == loadGetWord) begin
            wordReg <= {wordReg[wordWidth-9:0], rxByte};
        end
        if (wordComplete) begin
            wrAddr <= wordIdx;
        end
    end

    // word register is complete and stable while wrEn is high
    assign wrData = wordReg;

    // nothing gets written after the program is released
    aNoWriteWhenDone: assert property (
        @(posedge clk) disable iff (!rstN) (state == loadDone) |=> !wrEn
    );

    aEnableSticky: assert property (
        @(posedge clk) disable iff (!rstN) cpuEnable |=> cpuEnable
    );

endmodule

`default_nettype wire

//--- instrMem.sv
`default_nettype none
`timescale 1ns/1ps

module instrMem (
    input  wire                                 clk,
    input  wire                                 wrEn,
    input  wire  [bootPkg::memAddrWidth-1:0]    wrAddr,
    input  wire  [bootPkg::wordWidth-1:0]       wrData,
    input  wire  [31:0]                         fetchAddr,
    output logic [31:0]                         fetchData
);
    import bootPkg::*;

    logic [wordWidth-1:0] mem [memDepth];
    logic outOfRange;
    logic [memAddrWidth-1:0] rdAddr;

    // any address bit above the array range
    assign outOfRange = |fetchAddr[31:memAddrWidth];
    assign rdAddr = fetchAddr[memAddrWidth-1:0];

    // loader write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // fetch port, one cycle latency
    always_ff @(posedge clk) begin
        if (outOfRange) begin
            fetchData <= nopWord;
        end else begin
            fetchData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- bootTop.sv
`default_nettype none
`timescale 1ns/1ps

module bootTop #(
    parameter int clksPerBit = bootPkg::defaultClksPerBit
) (
    input  wire         clk,
    input  wire         rstN,
    input  wire         rx,
    input  wire  [31:0] fetchAddr,
    output logic [31:0] fetchData,
    output logic        cpuEnable,
    output logic        frameError
);
    import bootPkg::*;

    // receiver to loader
    logic [7:0] rxByte;
    logic rxValid;

    // loader to memory
    logic wrEn;
    logic [memAddrWidth-1:0] wrAddr;
    logic [wordWidth-1:0] wrData;

    uartRx #(
        .clksPerBit(clksPerBit)
    ) rx0 (
        .clk(clk),
        .rstN(rstN),
        .rx(rx),
        .rxByte(rxByte),
        .rxValid(rxValid),
        .frameError(frameError)
    );

    progLoader loader0 (
        .clk(clk),
        .rstN(rstN),
        .rxByte(rxByte),
        .rxValid(rxValid),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .cpuEnable(cpuEnable)
    );

    instrMem mem0 (
        .clk(clk),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData)
    );

endmodule

`default_nettype wire

//--- bootTb.sv
`default_nettype none
`timescale 1ns/1ps

module bootTb;
    import bootPkg::*;

    localparam int clksPerBit = 16;
    localparam int numWords = 6;
    localparam int numBadFrames = 2;
    localparam int numExtraBytes = 8;
    localparam int numFrames = 1 + 4 * numWords + numBadFrames + numExtraBytes;
    // every frame may be followed by up to three idle bit periods
    localparam int maxCycles = (numFrames + 3 * numFrames) * 10 * clksPerBit + memDepth + 200;

    logic clk;
    logic rstN;
    logic rx;
    logic [31:0] fetchAddr;
    wire [31:0] fetchData;
    wire cpuEnable;
    wire frameError;

    // program table of words and bad-frame flags
    // bit n of badBefore puts a corrupted frame ahead of byte n (byte 0 is the msb)
    logic [wordWidth-1:0] progWords [numWords];
    logic [3:0] badBefore [numWords];

    int errorCount;
    int checkCount;
    int expectedPulses;
    int cycleCount;
    logic [31:0] lcgState;

    // written only by the monitor
    int pulseCount = 0;
    int monitorErrors = 0;
    logic prevFrameError = 1'b0;
    logic enableSeen = 1'b0;

    bootTop #(
        .clksPerBit(clksPerBit)
    ) dut0 (
        .clk(clk),
        .rstN(rstN),
        .rx(rx),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData),
        .cpuEnable(cpuEnable),
        .frameError(frameError)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // always leaves the caller 1 ns after a rising edge
    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic driveBit(input logic value);
        rx = value;
        waitCycles(clksPerBit);
    endtask

    task automatic sendFrame(input logic [7:0] data, input logic badStop);
        int i;
        driveBit(1'b0);
        for (i = 0; i < 8; i++) begin
            driveBit(data[i]);
        end
        driveBit(!badStop);
    endtask

    task automatic sendGap(input int bits);
        repeat (bits) driveBit(1'b1);
    endtask

    task automatic randomGap(input int minBits);
        int bits;
        lcgState = lcgNext(lcgState);
        bits = int'(lcgState[31:30]);
        if (bits < minBits) begin
            bits = minBits;
        end
        sendGap(bits);
    endtask

    task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
        fetchAddr = addr;
        waitCycles(1);
        data = fetchData;
    endtask

    task automatic checkMemory(input string phase);
        logic [31:0] data;
        int i;
        for (i = 0; i < numWords; i++) begin
            readWord(32'(i), data);
            checkValue($sformatf("%s word %0d", phase, i), progWords[i], data);
        end
    endtask

    task automatic fillTable;
        progWords[0] = 32'h0000_0513;
        badBefore[0] = 4'b0000;
        progWords[1] = 32'h0010_0593;
        badBefore[1] = 4'b0100;
        progWords[2] = 32'h00b5_0633;
        badBefore[2] = 4'b0000;
        progWords[3] = 32'hdead_beef;
        badBefore[3] = 4'b0000;
        progWords[4] = 32'h8000_0001;
        badBefore[4] = 4'b1000;
        progWords[5] = 32'h0000_006f;
        badBefore[5] = 4'b0000;
    endtask

    task automatic sendProgram;
        int w;
        int b;
        logic [7:0] junk;
        sendFrame(8'(numWords), 1'b0);
        checkValue("cpuEnable after length byte", 32'd0, 32'(cpuEnable));
        randomGap(0);
        for (w = 0; w < numWords; w++) begin
            for (b = 0; b < 4; b++) begin
                if (badBefore[w][b]) begin
                    lcgState = lcgNext(lcgState);
                    junk = lcgState[23:16];
                    sendFrame(junk, 1'b1);
                    expectedPulses++;
                    checkValue("frameError pulse count", 32'(expectedPulses), 32'(pulseCount));
                    // line must go idle before the next start bit
                    randomGap(1);
                end
                sendFrame(progWords[w][31-8*b -: 8], 1'b0);
                checkValue("frameError pulse count", 32'(expectedPulses), 32'(pulseCount));
                if (!(w == numWords - 1 && b == 3)) begin
                    checkValue("cpuEnable before last byte", 32'd0, 32'(cpuEnable));
                    randomGap(0);
                end
            end
        end
    endtask

    // pulse counting and sticky enable watch
    always @(posedge clk) begin
        if (rstN) begin
            if (frameError) begin
                pulseCount++;
            end
            if (frameError && prevFrameError) begin
                monitorErrors++;
                $display("frameError stayed high for more than one cycle");
            end
            if (enableSeen && !cpuEnable) begin
                monitorErrors++;
                $display("cpuEnable fell after the program was loaded");
            end
            prevFrameError = frameError;
            enableSeen = enableSeen || cpuEnable;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", maxCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] data;
        int waited;
        int i;
        errorCount = 0;
        checkCount = 0;
        expectedPulses = 0;
        lcgState = 32'hb94e;
        rstN = 1'b0;
        rx = 1'b1;
        fetchAddr = 32'd0;
        fillTable();
        waitCycles(5);
        rstN = 1'b1;
        checkValue("cpuEnable after reset", 32'd0, 32'(cpuEnable));
        checkValue("frameError after reset", 32'd0, 32'(frameError));

        sendProgram();
        waited = 0;
        while (!cpuEnable && waited < 4 * clksPerBit) begin
            waitCycles(1);
            waited++;
        end
        if (!cpuEnable) begin
            errorCount++;
            $display("cpuEnable did not rise within 4 bit periods of the last stop bit");
        end
        checkMemory("load");

        // fetches above the array
        readWord(32'd256, data);
        checkValue("fetch 256", nopWord, data);
        readWord(32'hffff_0000, data);
        checkValue("fetch ffff0000", nopWord, data);

        // loader ignores trailing bytes once done
        for (i = 0; i < numExtraBytes; i++) begin
            lcgState = lcgNext(lcgState);
            sendFrame(lcgState[23:16], 1'b0);
            randomGap(0);
        end
        checkValue("cpuEnable after extra bytes", 32'd1, 32'(cpuEnable));
        checkValue("frameError pulse count", 32'(expectedPulses), 32'(pulseCount));
        checkMemory("after done");

        $display("errors: %0d, monitor errors: %0d, checks: %0d",
                 errorCount, monitorErrors, checkCount);
        if (errorCount + monitorErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
bootPkg.sv
uartRx.sv
progLoader.sv
instrMem.sv
bootTop.sv
bootTb.sv

//--- Makefile
# Verilator build and run for the serial boot loader

VERILATOR ?= verilator
TOP ?= bootTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Test completed successfully
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
